//--- Bender.yml
package:
  name: dual_issue_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - issue_unit.sv
      - alu_lane.sv
      - reg_file.sv
      - dual_issue_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dual_issue_core.sv

//--- alu_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module alu_lane (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::issue_slot_t  slot,
    input  wire core_pkg::lane_read_t   operands,
    output core_pkg::wb_t               wb
);
    import core_pkg::*;

    issue_slot_t ex_slot;
    lane_read_t  ex_ops;
    logic        ex_wr;
    word_t       imm_ext;
    word_t       op_a;
    word_t       op_b;
    word_t       result;
    logic        wb_en_q;
    reg_addr_t   wb_dest_q;
    word_t       wb_data_q;

    // Operand capture on the issue edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wr <= 1'b0;
        end else begin
            ex_wr <= slot.valid && slot.write_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_slot <= slot;
        ex_ops <= operands;
    end

    assign imm_ext = ex_slot.imm_zero_ext ?
                     {{(`CORE_XLEN-16){1'b0}}, ex_slot.immediate} :
                     {{(`CORE_XLEN-16){ex_slot.immediate[15]}}, ex_slot.immediate};

    assign op_a = ex_ops.rs_data;
    // rt is r0 for I-type and the immediate is zero for R-type
    assign op_b = ex_ops.rt_data | imm_ext;

    always_comb begin
        case (ex_slot.op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL: result = op_b << ex_slot.shamt;
            ALU_LUI: result = {ex_slot.immediate, {(`CORE_XLEN-16){1'b0}}};
            default: result = '0;
        endcase
    end

    // Result register feeding writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= ex_wr;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest_q <= ex_slot.dest;
        wb_data_q <= result;
    end

    assign wb = '{write_en: wb_en_q, dest: wb_dest_q, data: wb_data_q};

    wb_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wb.write_en |-> $past(slot.valid && slot.write_en, 2));

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_addr_t;

    // MIPS primary opcodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    // Word 0 is the older instruction
    typedef struct packed {
        logic [31:0] word1;
        logic [31:0] word0;
    } inst_bundle_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t dest;
        logic      write_en;
        logic      imm_zero_ext;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [15:0] immediate;
        logic [4:0]  shamt;
    } issue_slot_t;

    typedef struct packed {
        word_t rs_data;
        word_t rt_data;
    } lane_read_t;

    typedef struct packed {
        logic      write_en;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

    typedef enum logic {
        WAIT_REQ,
        WAIT_RELEASE
    } ack_state_e;

endpackage

`default_nettype wire

//--- core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data word width
`define CORE_XLEN 32

// Architectural registers including r0
`define CORE_NUM_REGS 32

// Issue lanes
// Pairing and writeback priority assume exactly two
`define CORE_LANES 2

// Fetch queue entries
// Any power of two of at least 2 works
`define CORE_QUEUE_DEPTH 4

`endif

//--- dual_issue_core.f
+incdir+.
core_pkg.sv
issue_unit.sv
alu_lane.sv
reg_file.sv
dual_issue_core.sv
tb_dual_issue_core.sv

//--- dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module dual_issue_core (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          inst_req,
    output logic                         inst_ack,
    input  wire core_pkg::inst_bundle_t  bundle,
    output core_pkg::wb_t                retire [`CORE_LANES]
);
    import core_pkg::*;

    issue_slot_t               slots [`CORE_LANES];
    lane_read_t                reads [`CORE_LANES];
    wb_t                       wb    [`CORE_LANES];
    logic [`CORE_NUM_REGS-1:0] busy;

    // Pairing logic is written for two lanes
    if (`CORE_LANES != 2) begin : g_lane_check
        $fatal(1, "CORE_LANES must be 2");
    end

    issue_unit u_issue (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .bundle   (bundle),
        .busy     (busy),
        .slots    (slots)
    );

    for (genvar i = 0; i < `CORE_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .slot     (slots[i]),
            .operands (reads[i]),
            .wb       (wb[i])
        );
    end

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .slots  (slots),
        .reads  (reads),
        .busy   (busy),
        .wb     (wb),
        .retire (retire)
    );

endmodule

`default_nettype wire

//--- issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module issue_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          inst_req,
    output logic                         inst_ack,
    input  wire core_pkg::inst_bundle_t  bundle,
    input  wire [`CORE_NUM_REGS-1:0]     busy,
    output core_pkg::issue_slot_t        slots [`CORE_LANES]
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(`CORE_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ack_state_e       state;
    logic [31:0]      queue [`CORE_QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_next;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_next;
    logic [CNT_W-1:0] count;
    logic             push;
    logic [1:0]       pop;
    issue_slot_t      head;
    issue_slot_t      second;
    logic             head_writes;
    logic             issue0;
    logic             issue1;

    // I-type slots keep rt at r0 and R-type slots a zero immediate,
    // so the lane can merge both into operand B
    function automatic issue_slot_t decode(input logic [31:0] inst);
        issue_slot_t s;
        s = '0;
        s.rs = inst[25:21];
        s.shamt = inst[10:6];
        s.write_en = 1'b1;
        if (inst[31:26] == OP_SPECIAL) begin
            s.rt = inst[20:16];
            s.dest = inst[15:11];
            case (inst[5:0])
                FN_SLL:  s.op = ALU_SLL;
                FN_ADDU: s.op = ALU_ADD;
                FN_SUBU: s.op = ALU_SUB;
                FN_AND:  s.op = ALU_AND;
                FN_OR:   s.op = ALU_OR;
                FN_XOR:  s.op = ALU_XOR;
                FN_SLT:  s.op = ALU_SLT;
                default: s.write_en = 1'b0;
            endcase
        end else begin
            s.dest = inst[20:16];
            s.immediate = inst[15:0];
            s.imm_zero_ext = (inst[31:26] == OP_ANDI) || (inst[31:26] == OP_ORI) ||
                             (inst[31:26] == OP_XORI);
            case (inst[31:26])
                OP_ADDIU: s.op = ALU_ADD;
                OP_SLTI:  s.op = ALU_SLT;
                OP_ANDI:  s.op = ALU_AND;
                OP_ORI:   s.op = ALU_OR;
                OP_XORI:  s.op = ALU_XOR;
                OP_LUI: begin
                    s.op = ALU_LUI;
                    s.rs = '0;
                end
                default:  s.write_en = 1'b0;
            endcase
        end
        // Undefined encodings become a bubble with no sources
        if (!s.write_en) begin
            s.rs = '0;
            s.rt = '0;
            s.dest = '0;
        end
        return s;
    endfunction

    assign inst_ack = (state == WAIT_RELEASE);
    assign push = (state == WAIT_REQ) && inst_req && (count <= CNT_W'(`CORE_QUEUE_DEPTH - 2));
    assign rd_next = rd_ptr + 1'b1;
    assign wr_next = wr_ptr + 1'b1;

    assign head = decode(queue[rd_ptr]);
    assign second = decode(queue[rd_next]);
    assign head_writes = head.write_en && (head.dest != '0);

    assign issue0 = (count != '0) && !busy[head.rs] && !busy[head.rt] &&
                    !(head.write_en && busy[head.dest]);
    assign issue1 = issue0 && (count >= CNT_W'(2)) && !busy[second.rs] && !busy[second.rt] &&
                    !(second.write_en && busy[second.dest]) &&
                    !(head_writes && ((second.rs == head.dest) || (second.rt == head.dest)));
    assign pop = {1'b0, issue0} + {1'b0, issue1};

    always_comb begin
        slots[0] = head;
        slots[0].valid = issue0;
        slots[1] = second;
        slots[1].valid = issue1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_REQ;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (push) begin
                        state <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE: begin
                    if (!inst_req) begin
                        state <= WAIT_REQ;
                    end
                end
                default: state <= WAIT_REQ;
            endcase
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(2);
            end
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count <= count + CNT_W'(push ? 2 : 0) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= bundle.word0;
            queue[wr_next] <= bundle.word1;
        end
    end

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack) |-> $past(inst_req));

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::issue_slot_t  slots [`CORE_LANES],
    output core_pkg::lane_read_t        reads [`CORE_LANES],
    output logic [`CORE_NUM_REGS-1:0]   busy,
    input  wire core_pkg::wb_t          wb [`CORE_LANES],
    output core_pkg::wb_t               retire [`CORE_LANES]
);
    import core_pkg::*;

    word_t regs [`CORE_NUM_REGS];

    // r0 stays zero from reset since retire never writes it
    always_comb begin
        for (int l = 0; l < `CORE_LANES; l++) begin
            reads[l].rs_data = regs[slots[l].rs];
            reads[l].rt_data = regs[slots[l].rt];
        end
    end

    always_comb begin
        for (int l = 0; l < `CORE_LANES; l++) begin
            retire[l] = wb[l];
            retire[l].write_en = wb[l].write_en && (wb[l].dest != '0);
        end
    end

    // Later lane overwrites the earlier one on a shared dest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `CORE_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `CORE_LANES; l++) begin
                if (retire[l].write_en) begin
                    regs[retire[l].dest] <= retire[l].data;
                end
            end
        end
    end

    // Clear on write, set on issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            for (int l = 0; l < `CORE_LANES; l++) begin
                if (retire[l].write_en) begin
                    busy[retire[l].dest] <= 1'b0;
                end
            end
            for (int l = 0; l < `CORE_LANES; l++) begin
                if (slots[l].valid && slots[l].write_en && (slots[l].dest != '0)) begin
                    busy[slots[l].dest] <= 1'b1;
                end
            end
        end
    end

    for (genvar l = 0; l < `CORE_LANES; l++) begin : g_chk
        write_hits_busy: assert property (@(posedge clk) disable iff (!rst_n)
            retire[l].write_en |-> busy[retire[l].dest]);
    end

endmodule

`default_nettype wire

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
endfunction

function automatic logic [31:0] enc_r(input funct_e fn, input reg_addr_t rd,
                                      input reg_addr_t rs, input reg_addr_t rt,
                                      input logic [4:0] shamt);
    return {OP_SPECIAL, rs, rt, rd, shamt, fn};
endfunction

function automatic logic [31:0] enc_i(input opcode_e op, input reg_addr_t rt,
                                      input reg_addr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Reference MIPS semantics
// Returns 0 for encodings outside the kept set
function automatic logic ref_execute(input logic [31:0] inst, input word_t rs_val,
                                     input word_t rt_val, output reg_addr_t dest,
                                     output word_t value);
    word_t sext;
    word_t zext;
    sext = {{16{inst[15]}}, inst[15:0]};
    zext = {16'h0000, inst[15:0]};
    value = '0;
    ref_execute = 1'b1;
    if (inst[31:26] == OP_SPECIAL) begin
        dest = inst[15:11];
        case (inst[5:0])
            FN_SLL:  value = rt_val << inst[10:6];
            FN_ADDU: value = rs_val + rt_val;
            FN_SUBU: value = rs_val - rt_val;
            FN_AND:  value = rs_val & rt_val;
            FN_OR:   value = rs_val | rt_val;
            FN_XOR:  value = rs_val ^ rt_val;
            FN_SLT:  value = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
            default: ref_execute = 1'b0;
        endcase
    end else begin
        dest = inst[20:16];
        case (inst[31:26])
            OP_ADDIU: value = rs_val + sext;
            OP_SLTI:  value = ($signed(rs_val) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_ANDI:  value = rs_val & zext;
            OP_ORI:   value = rs_val | zext;
            OP_XORI:  value = rs_val ^ zext;
            OP_LUI:   value = {inst[15:0], 16'h0000};
            default:  ref_execute = 1'b0;
        endcase
    end
endfunction

`endif

//--- tb_dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module tb_dual_issue_core;
    import core_pkg::*;

    `include "tb_model.svh"

    localparam int ACK_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 1000;
    localparam int EXP_DEPTH     = 1024;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         inst_req;
    logic         inst_ack;
    inst_bundle_t bundle;
    wb_t          retire [`CORE_LANES];

    logic [15:0]  lfsr_state = 16'd5;
    word_t        model_regs [`CORE_NUM_REGS];
    reg_addr_t    exp_dest [EXP_DEPTH];
    word_t        exp_data [EXP_DEPTH];
    int           wr_idx = 0;
    int           rd_idx;
    int           exp_idx [`CORE_LANES];
    logic         saw_dual = 1'b0;
    logic         saw_backpressure = 1'b0;

    dual_issue_core uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .bundle   (bundle),
        .retire   (retire)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Mostly r0 to r7 so that dependences are frequent
    function automatic reg_addr_t rand_reg();
        if (rand_bits(2) == 0) begin
            return reg_addr_t'(rand_bits(5));
        end
        return reg_addr_t'(rand_bits(3));
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [3:0]  kind;
        reg_addr_t   rd;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
        logic [4:0]  shamt;
        kind = 4'(rand_bits(4));
        rd = rand_reg();
        rs = rand_reg();
        rt = rand_reg();
        imm = 16'(rand_bits(16));
        shamt = 5'(rand_bits(5));
        case (kind)
            0:  return enc_r(FN_ADDU, rd, rs, rt, 5'd0);
            1:  return enc_r(FN_SUBU, rd, rs, rt, 5'd0);
            2:  return enc_r(FN_AND, rd, rs, rt, 5'd0);
            3:  return enc_r(FN_OR, rd, rs, rt, 5'd0);
            4:  return enc_r(FN_XOR, rd, rs, rt, 5'd0);
            5:  return enc_r(FN_SLT, rd, rs, rt, 5'd0);
            6:  return enc_r(FN_SLL, rd, 5'd0, rt, shamt);
            7:  return enc_i(OP_ADDIU, rt, rs, imm);
            8:  return enc_i(OP_SLTI, rt, rs, imm);
            9:  return enc_i(OP_ANDI, rt, rs, imm);
            10: return enc_i(OP_ORI, rt, rs, imm);
            11: return enc_i(OP_XORI, rt, rs, imm);
            12: return enc_i(OP_LUI, rt, 5'd0, imm);
            // LW, JR and BEQ are outside the kept set
            13: return {6'h23, rs, rt, imm};
            14: return {6'h00, rs, 5'd0, 5'd0, 5'd0, 6'h08};
            default: return {6'h04, rs, rt, imm};
        endcase
    endfunction

    task automatic record_expected(input logic [31:0] inst);
        reg_addr_t dest;
        word_t     value;
        if (ref_execute(inst, model_regs[inst[25:21]], model_regs[inst[20:16]], dest, value) &&
            (dest != '0)) begin
            model_regs[dest] = value;
            exp_dest[wr_idx] = dest;
            exp_data[wr_idx] = value;
            wr_idx++;
        end
    endtask

    task automatic send_bundle(input logic [31:0] w0, input logic [31:0] w1);
        int waited;
        record_expected(w0);
        record_expected(w1);
        @(posedge clk);
        #1;
        bundle = '{word1: w1, word0: w0};
        inst_req = 1'b1;
        waited = 0;
        while (!inst_ack) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_with_failure("timeout waiting for inst_ack to rise");
            end
        end
        if (waited > 1) begin
            saw_backpressure = 1'b1;
        end
        inst_req = 1'b0;
        waited = 0;
        while (inst_ack) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_with_failure("timeout waiting for inst_ack to fall");
            end
        end
    endtask

    // Lane 1 takes the entry after lane 0 when both retire
    always_comb begin
        exp_idx[0] = rd_idx;
        exp_idx[1] = rd_idx + int'(retire[0].write_en);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx <= 0;
        end else begin
            rd_idx <= rd_idx + int'(retire[0].write_en) + int'(retire[1].write_en);
            if (retire[0].write_en && retire[1].write_en) begin
                saw_dual <= 1'b1;
            end
        end
    end

    for (genvar l = 0; l < `CORE_LANES; l++) begin : g_check
        retire_expected: assert property (@(posedge clk) disable iff (!rst_n)
            retire[l].write_en |-> (exp_idx[l] < wr_idx))
        else stop_with_failure($sformatf("lane %0d retired a write that was not expected", l));

        retire_dest: assert property (@(posedge clk) disable iff (!rst_n)
            retire[l].write_en |-> (retire[l].dest == exp_dest[exp_idx[l]]))
        else stop_with_failure($sformatf("FAILED %0t retire[%0d].dest expected %0d got %0d",
            $time, l, exp_dest[$sampled(exp_idx[l])], $sampled(retire[l].dest)));

        retire_data: assert property (@(posedge clk) disable iff (!rst_n)
            retire[l].write_en |-> (retire[l].data == exp_data[exp_idx[l]]))
        else stop_with_failure($sformatf("FAILED %0t retire[%0d].data expected %h got %h",
            $time, l, exp_data[$sampled(exp_idx[l])], $sampled(retire[l].data)));
    end

    ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack) |-> $past(inst_req))
    else stop_with_failure("inst_ack rose while inst_req was low");

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(inst_ack) |-> !$past(inst_req))
    else stop_with_failure("inst_ack fell while inst_req was still high");

    initial begin
        int waited;
        rst_n = 1'b0;
        inst_req = 1'b0;
        bundle = '0;
        for (int r = 0; r < `CORE_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Independent pairs reading r0
        for (int i = 0; i < 8; i++) begin
            send_bundle(enc_i(OP_ADDIU, reg_addr_t'(16 + 2 * i), 5'd0, 16'(16'h8001 + i)),
                        enc_i(OP_ORI, reg_addr_t'(17 + 2 * i), 5'd0, 16'(16'h00f0 + i)));
        end

        // Long dependence chains back up the queue
        for (int i = 0; i < 12; i++) begin
            send_bundle(enc_r(FN_ADDU, 5'd16, 5'd16, 5'd17, 5'd0),
                        enc_i(OP_XORI, 5'd16, 5'd16, 16'(16'h1234 * (i + 1))));
        end

        for (int b = 0; b < 300; b++) begin
            send_bundle(rand_inst(), rand_inst());
        end

        waited = 0;
        while (rd_idx != wr_idx) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_with_failure("timeout waiting for expected writes to retire");
            end
        end

        if (!saw_dual || !saw_backpressure) begin
            stop_with_failure("no dual retire or no back-pressure was seen");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
